/* logic/dct_defines.svh */
// Widths, rounding position, DC level offset and the row DCT basis weights
// Weights are cosine values scaled by 2^14

`ifndef DCT_DEFINES_SVH
`define DCT_DEFINES_SVH

// Row geometry
`define DCT_N            8
`define DCT_IDX_W        3
`define DCT_PIX_W        8

// Datapath widths, all signed except the pixel
`define DCT_WEIGHT_W     15
`define DCT_PROD_W       24
`define DCT_ACC_W        27
`define DCT_FRAC_BITS    12
`define DCT_COEF_W       13

// 128 * 8 * DCT_T1, removed from coefficient 0 since pixels are not centred
`define DCT_LEVEL_OFFSET 5932032

// DC weight and its negated form used by basis 4
`define DCT_T1           5793
`define DCT_T52          (-5793)

// Odd basis magnitudes
`define DCT_T21          8035
`define DCT_T22          6811
`define DCT_T23          4551
`define DCT_T24          1598
`define DCT_T25          (-1598)
`define DCT_T26          (-4551)
`define DCT_T27          (-6811)
`define DCT_T28          (-8035)

// Bases 2 and 6
`define DCT_T31          7568
`define DCT_T32          3135
`define DCT_T33          (-3135)
`define DCT_T34          (-7568)

`endif

/* logic/dct_pkg.sv */
// Shared types of the row DCT: stage enables, weight column, accumulator row
// and coefficient row

`include "dct_defines.svh"

package dct_pkg;

	// Stage enables produced by the controller
	typedef struct packed {
		logic mul_en;
		logic acc_load;
		logic acc_en;
		logic round_en;
	} dct_ctrl_t;

	typedef logic signed [`DCT_WEIGHT_W-1:0] dct_weight_t;
	typedef logic signed [`DCT_ACC_W-1:0]    dct_acc_t;
	typedef logic signed [`DCT_COEF_W-1:0]   dct_coef_t;

	// Entry k belongs to basis k
	typedef dct_weight_t [`DCT_N-1:0] dct_weights_t;
	typedef dct_acc_t    [`DCT_N-1:0] dct_acc_row_t;
	typedef dct_coef_t   [`DCT_N-1:0] dct_row_t;

endpackage

/* logic/dct_row_ctrl.sv */
// Pixel index counter and the flag pipeline that times multiply,
// accumulate and rounding

`timescale 1ns/1ps

`include "dct_defines.svh"

module dct_row_ctrl (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  enable,
	output logic [`DCT_IDX_W-1:0] pix_index,
	output dct_pkg::dct_ctrl_t    stage
);

	logic valid_1;
	logic first_1;
	logic last_1;
	logic valid_2;
	logic first_2;
	logic last_2;
	logic last_3;

	// Dropping enable abandons the partial row
	always_ff @(posedge clk) begin
		if (rst) begin
			pix_index <= '0;
		end else if (!enable) begin
			pix_index <= '0;
		end else begin
			pix_index <= pix_index + 1'b1;
		end
	end

	// Flags travel alongside the pixel: product, accumulate, then round
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_1 <= 1'b0;
			first_1 <= 1'b0;
			last_1  <= 1'b0;
			valid_2 <= 1'b0;
			first_2 <= 1'b0;
			last_2  <= 1'b0;
			last_3  <= 1'b0;
		end else begin
			valid_1 <= enable;
			first_1 <= enable && (pix_index == '0);
			last_1  <= enable && (pix_index == `DCT_IDX_W'(`DCT_N - 1));
			valid_2 <= valid_1;
			first_2 <= first_1;
			last_2  <= last_1;
			last_3  <= last_2;
		end
	end

	always_comb begin
		stage.mul_en   = valid_1;
		stage.acc_load = valid_2 && first_2;
		stage.acc_en   = valid_2 && !first_2;
		stage.round_en = last_3;
	end

	// A full row takes eight pixels, so two results can never be closer
	a_round_spacing: assert property (@(posedge clk) disable iff (rst)
		stage.round_en |=> !stage.round_en [*(`DCT_N - 1)])
		else $error("round_en pulses closer than %0d cycles", `DCT_N);

endmodule

/* logic/dct_weight_stage.sv */
// Basis weight table indexed by pixel position, with the pixel and weight
// column registers feeding the MAC lanes

`timescale 1ns/1ps

`include "dct_defines.svh"

module dct_weight_stage (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   enable,
	input  logic [`DCT_IDX_W-1:0]  pix_index,
	input  logic [`DCT_PIX_W-1:0]  pixel,
	output logic [`DCT_PIX_W-1:0]  pixel_q,
	output dct_pkg::dct_weights_t  weights
);

	localparam dct_pkg::dct_weight_t w1  = `DCT_T1;
	localparam dct_pkg::dct_weight_t w52 = `DCT_T52;
	localparam dct_pkg::dct_weight_t w21 = `DCT_T21;
	localparam dct_pkg::dct_weight_t w22 = `DCT_T22;
	localparam dct_pkg::dct_weight_t w23 = `DCT_T23;
	localparam dct_pkg::dct_weight_t w24 = `DCT_T24;
	localparam dct_pkg::dct_weight_t w25 = `DCT_T25;
	localparam dct_pkg::dct_weight_t w26 = `DCT_T26;
	localparam dct_pkg::dct_weight_t w27 = `DCT_T27;
	localparam dct_pkg::dct_weight_t w28 = `DCT_T28;
	localparam dct_pkg::dct_weight_t w31 = `DCT_T31;
	localparam dct_pkg::dct_weight_t w32 = `DCT_T32;
	localparam dct_pkg::dct_weight_t w33 = `DCT_T33;
	localparam dct_pkg::dct_weight_t w34 = `DCT_T34;

	dct_pkg::dct_weights_t weight_col;

	// One column of the basis matrix per pixel position
	// Each list runs from lane 7 down to lane 0
	always_comb begin
		case (pix_index)
			3'd0: weight_col = {w24, w32, w23, w1,
			                    w22, w31, w21, w1};
			3'd1: weight_col = {w26, w34, w28, w52,
			                    w25, w32, w22, w1};
			3'd2: weight_col = {w22, w31, w24, w52,
			                    w28, w33, w23, w1};
			3'd3: weight_col = {w28, w33, w22, w1,
			                    w26, w34, w24, w1};
			3'd4: weight_col = {w21, w33, w27, w1,
			                    w23, w34, w25, w1};
			3'd5: weight_col = {w27, w31, w25, w52,
			                    w21, w33, w26, w1};
			3'd6: weight_col = {w23, w34, w21, w52,
			                    w24, w32, w27, w1};
			default: weight_col = {w25, w32, w26, w1,
			                       w27, w31, w28, w1};
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pixel_q <= '0;
			weights <= '0;
		end else if (enable) begin
			pixel_q <= pixel;
			weights <= weight_col;
		end
	end

endmodule

/* logic/dct_mac_lane.sv */
// One basis row of the row DCT: product register and accumulator

`timescale 1ns/1ps

`include "dct_defines.svh"

module dct_mac_lane (
	input  logic                            clk,
	input  logic                            rst,
	input  logic        [`DCT_PIX_W-1:0]    pixel_q,
	input  logic signed [`DCT_WEIGHT_W-1:0] weight,
	input  logic                            mul_en,
	input  logic                            acc_load,
	input  logic                            acc_en,
	output logic signed [`DCT_ACC_W-1:0]    acc
);

	logic signed [`DCT_PROD_W-1:0] prod;

	// Pixel is unsigned, so a zero bit on top keeps the product signed correctly
	always_ff @(posedge clk) begin
		if (mul_en) begin
			prod <= $signed({1'b0, pixel_q}) * weight;
		end
	end

	// First pixel of a row starts a fresh sum
	always_ff @(posedge clk) begin
		if (acc_load) begin
			acc <= prod;
		end else if (acc_en) begin
			acc <= acc + prod;
		end
	end

	a_load_add_excl: assert property (@(posedge clk) disable iff (rst)
		!(acc_load && acc_en))
		else $error("acc_load and acc_en high together");

endmodule

/* logic/dct_row_round.sv */
// DC level shift, rounding to coefficient width and the output register

`timescale 1ns/1ps

`include "dct_defines.svh"

module dct_row_round (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  round_en,
	input  dct_pkg::dct_acc_row_t acc_row,
	output dct_pkg::dct_row_t     coefs,
	output logic                  out_valid
);

	dct_pkg::dct_acc_t level   [`DCT_N];
	dct_pkg::dct_acc_t rounded [`DCT_N];

	// Only basis 0 has a non-zero weight sum, so only it needs the offset
	always_comb begin
		for (int k = 0; k < `DCT_N; k++) begin
			level[k] = acc_row[k];
			if (k == 0) begin
				level[k] = acc_row[k] - `DCT_LEVEL_OFFSET;
			end
			rounded[k] = (level[k] >>> `DCT_FRAC_BITS)
				+ $signed({1'b0, level[k][`DCT_FRAC_BITS-1]});
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			coefs     <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= round_en;
			if (round_en) begin
				for (int k = 0; k < `DCT_N; k++) begin
					coefs[k] <= rounded[k][`DCT_COEF_W-1:0];
				end
			end
		end
	end

	// Result must survive truncation to the coefficient width
	for (genvar k = 0; k < `DCT_N; k++) begin : gen_fit
		a_coef_fits: assert property (@(posedge clk) disable iff (rst)
			round_en |-> (rounded[k] >= -(2 ** (`DCT_COEF_W - 1)))
				&& (rounded[k] < (2 ** (`DCT_COEF_W - 1))))
			else $error("coefficient %0d out of range: %0d", k, rounded[k]);
	end

endmodule

/* logic/dct_row_top.sv */
// Row DCT top level: controller, weight stage, eight MAC lanes and the
// rounding stage

`timescale 1ns/1ps

`include "dct_defines.svh"

module dct_row_top (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  enable,
	input  logic [`DCT_PIX_W-1:0] pixel,
	output dct_pkg::dct_row_t     coefs,
	output logic                  out_valid
);

	logic [`DCT_IDX_W-1:0] pix_index;
	logic [`DCT_PIX_W-1:0] pixel_q;
	dct_pkg::dct_ctrl_t    stage;
	dct_pkg::dct_weights_t weights;
	dct_pkg::dct_acc_row_t acc_row;

	dct_row_ctrl i_dct_row_ctrl (
		.clk       (clk),
		.rst       (rst),
		.enable    (enable),
		.pix_index (pix_index),
		.stage     (stage)
	);

	dct_weight_stage i_dct_weight_stage (
		.clk       (clk),
		.rst       (rst),
		.enable    (enable),
		.pix_index (pix_index),
		.pixel     (pixel),
		.pixel_q   (pixel_q),
		.weights   (weights)
	);

	// Lane k computes basis k
	for (genvar k = 0; k < `DCT_N; k++) begin : gen_lane
		dct_mac_lane i_dct_mac_lane (
			.clk      (clk),
			.rst      (rst),
			.pixel_q  (pixel_q),
			.weight   (weights[k]),
			.mul_en   (stage.mul_en),
			.acc_load (stage.acc_load),
			.acc_en   (stage.acc_en),
			.acc      (acc_row[k])
		);
	end

	dct_row_round i_dct_row_round (
		.clk       (clk),
		.rst       (rst),
		.round_en  (stage.round_en),
		.acc_row   (acc_row),
		.coefs     (coefs),
		.out_valid (out_valid)
	);

endmodule

/* sim/dct_row_model.svh */
// Testbench LFSR step and the reference row DCT built from the cosine basis

typedef logic [`DCT_N-1:0][`DCT_PIX_W-1:0] pix_row_t;

// Fibonacci LFSR with taps 32, 22, 2 and 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	logic fb;
	fb = s[31] ^ s[21] ^ s[1] ^ s[0];
	return {s[30:0], fb};
endfunction

// Weight of basis k at pixel n, from cos((2n+1)k*pi/16) folded into the first quadrant
function automatic int basis_weight(input int k, input int n);
	int m;
	int sign;
	int mag;
	if (k == 0) return `DCT_T1;
	m = ((2 * n + 1) * k) % 32;
	sign = 1;
	if (m > 16) m = 32 - m;
	if (m > 8) begin
		sign = -1;
		m = 16 - m;
	end
	case (m)
		1: mag = `DCT_T21;
		2: mag = `DCT_T31;
		3: mag = `DCT_T22;
		4: mag = `DCT_T1;
		5: mag = `DCT_T23;
		6: mag = `DCT_T32;
		7: mag = `DCT_T24;
		default: mag = 0;
	endcase
	return sign * mag;
endfunction

function automatic dct_pkg::dct_row_t row_dct(input pix_row_t pix);
	dct_pkg::dct_row_t res;
	longint acc;
	longint q;
	for (int k = 0; k < `DCT_N; k++) begin
		acc = 0;
		for (int n = 0; n < `DCT_N; n++) begin
			acc = acc + longint'(pix[n]) * basis_weight(k, n);
		end
		if (k == 0) acc = acc - `DCT_LEVEL_OFFSET;
		// Round half up on the dropped fraction
		q = (acc >>> `DCT_FRAC_BITS) + acc[`DCT_FRAC_BITS-1];
		res[k] = q[`DCT_COEF_W-1:0];
	end
	return res;
endfunction

/* sim/dct_row_tb.sv */
// Row DCT testbench: clock, reset, row stimulus, assertion checks,
// per-test reporting and the cycle limit

`timescale 1ns/1ps

`include "dct_defines.svh"

module dct_row_tb;

	localparam int reset_cycles  = 4;
	localparam int quiet_cycles  = 6;
	localparam int random_rows   = 20;
	localparam int broken_len    = 5;
	localparam int gap_cycles    = 3;
	localparam int drain_cycles  = 8;
	localparam int pixels_driven = (3 + random_rows + 2 + 1) * `DCT_N + broken_len;
	localparam int idle_cycles   = reset_cycles + quiet_cycles + gap_cycles + 4 * drain_cycles;
	localparam int cycle_limit   = pixels_driven + idle_cycles + 50;

	logic                  clk = 1'b0;
	logic                  rst;
	logic                  enable;
	logic [`DCT_PIX_W-1:0] pixel;
	dct_pkg::dct_row_t     coefs;
	logic                  out_valid;

	logic              row_end;
	logic              row_given;
	logic [31:0]       lfsr_state;
	dct_pkg::dct_row_t exp_q [$];
	dct_pkg::dct_row_t exp_head = '0;
	int                errors = 0;
	int                cycles = 0;
	int                rows_checked = 0;
	int                tests_passed = 0;
	int                tests_failed = 0;

	`include "dct_row_model.svh"

	dct_row_top i_dct_row_top (
		.clk       (clk),
		.rst       (rst),
		.enable    (enable),
		.pixel     (pixel),
		.coefs     (coefs),
		.out_valid (out_valid)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles with %0d rows still unchecked",
				cycles, exp_q.size());
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// The expected row moves to the head half a cycle before the check samples it
	always @(negedge clk) begin
		if (!rst && out_valid) begin
			if (exp_q.size() == 0) begin
				$display("out_valid pulsed with no complete row waiting to be checked");
				errors++;
			end else begin
				exp_head = exp_q.pop_front();
				rows_checked++;
			end
		end
	end

	task automatic report_row_mismatch(input dct_pkg::dct_row_t got,
		input dct_pkg::dct_row_t want);
		for (int k = 0; k < `DCT_N; k++) begin
			if (got[k] !== want[k]) begin
				$display("FAIL coefs[%0d]: got 0x%h, expected 0x%h", k, got[k], want[k]);
			end
		end
		errors++;
	endtask

	a_row_match: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> coefs == exp_head)
		else report_row_mismatch($sampled(coefs), $sampled(exp_head));

	a_quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
		!row_given |-> (!out_valid && coefs == '0))
		else begin
			$display("Output moved after reset before any full row was given");
			errors++;
		end

	// Last pixel sampled at E gives out_valid over E+3 to E+4, then low again
	a_latency: assert property (@(posedge clk) disable iff (rst)
		(enable && row_end) |-> ##4 out_valid ##1 !out_valid)
		else begin
			$display("out_valid not a single pulse 3 cycles after a row's last pixel");
			errors++;
		end

	a_spacing: assert property (@(posedge clk) disable iff (rst)
		out_valid |=> !out_valid [*(`DCT_N - 1)])
		else begin
			$display("Two out_valid pulses closer than %0d cycles", `DCT_N);
			errors++;
		end

	function automatic logic [`DCT_PIX_W-1:0] random_pixel();
		logic [`DCT_PIX_W-1:0] p;
		for (int b = 0; b < `DCT_PIX_W; b++) begin
			lfsr_state = lfsr_step(lfsr_state);
			p[b] = lfsr_state[0];
		end
		return p;
	endfunction

	task automatic drive_row(input pix_row_t pix, input dct_pkg::dct_row_t expected);
		for (int n = 0; n < `DCT_N; n++) begin
			@(negedge clk);
			enable  = 1'b1;
			pixel   = pix[n];
			row_end = (n == `DCT_N - 1);
		end
		exp_q.push_back(expected);
		row_given = 1'b1;
	endtask

	task automatic go_idle(input int n);
		repeat (n) begin
			@(negedge clk);
			enable  = 1'b0;
			row_end = 1'b0;
		end
	endtask

	// The queue only changes on falling edges, so it is polled on rising ones
	task automatic wait_drained();
		go_idle(1);
		while (exp_q.size() != 0) @(posedge clk);
		@(posedge clk);
		@(negedge clk);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			$display("%s: passed", name);
			tests_passed++;
		end else begin
			$display("%s: failed with %0d errors", name, errors - errors_before);
			tests_failed++;
		end
	endtask

	initial begin
		int                errs_before;
		pix_row_t          pix;
		dct_pkg::dct_row_t expected;
		logic [7:0]        flat_val [3];

		rst        = 1'b1;
		enable     = 1'b0;
		pixel      = '0;
		row_end    = 1'b0;
		row_given  = 1'b0;
		lfsr_state = 32'h24c4;
		flat_val   = '{8'd128, 8'd255, 8'd0};
		repeat (reset_cycles) @(negedge clk);
		rst = 1'b0;

		errs_before = errors;
		go_idle(quiet_cycles);
		finish_test("after reset", errs_before);

		errs_before = errors;
		for (int i = 0; i < 3; i++) begin
			pix = {`DCT_N{flat_val[i]}};
			expected = '0;
			if (flat_val[i] == 8'd255) expected[0] = 13'sd1437;
			if (flat_val[i] == 8'd0) expected[0] = -13'sd1448;
			drive_row(pix, expected);
		end
		wait_drained();
		finish_test("flat rows", errs_before);

		errs_before = errors;
		for (int r = 0; r < random_rows; r++) begin
			for (int n = 0; n < `DCT_N; n++) begin
				pix[n] = random_pixel();
			end
			drive_row(pix, row_dct(pix));
		end
		wait_drained();
		finish_test("random back-to-back rows", errs_before);

		// Two ramps back to back, so the pulses must land 8 cycles apart
		errs_before = errors;
		for (int n = 0; n < `DCT_N; n++) begin
			pix[n] = 8'(n * 36);
		end
		drive_row(pix, row_dct(pix));
		for (int n = 0; n < `DCT_N; n++) begin
			pix[n] = 8'(255 - n * 36);
		end
		drive_row(pix, row_dct(pix));
		wait_drained();
		finish_test("latency", errs_before);

		errs_before = errors;
		for (int n = 0; n < broken_len; n++) begin
			@(negedge clk);
			enable  = 1'b1;
			pixel   = random_pixel();
			row_end = 1'b0;
		end
		go_idle(gap_cycles);
		for (int n = 0; n < `DCT_N; n++) begin
			pix[n] = random_pixel();
		end
		drive_row(pix, row_dct(pix));
		wait_drained();
		finish_test("broken row", errs_before);

		$display("Tests passed %0d, failed %0d, rows checked %0d",
			tests_passed, tests_failed, rows_checked);
		if (tests_failed == 0 && errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* sources.f */
+incdir+logic
+incdir+sim
logic/dct_pkg.sv
logic/dct_row_ctrl.sv
logic/dct_weight_stage.sv
logic/dct_mac_lane.sv
logic/dct_row_round.sv
logic/dct_row_top.sv
sim/dct_row_tb.sv

/* Bender.yml */
package:
  name: dct_row

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/dct_pkg.sv
      - logic/dct_row_ctrl.sv
      - logic/dct_weight_stage.sv
      - logic/dct_mac_lane.sv
      - logic/dct_row_round.sv
      - logic/dct_row_top.sv
  - target: simulation
    include_dirs:
      - logic
      - sim
    files:
      - sim/dct_row_tb.sv
